// File: Makefile
# Verilator simulation of the radar-scene channel controller

VERILATOR ?= verilator
TOP       ?= tb_drbe_local_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+verilog
verilog/drbe_pkg.sv
verilog/scenario_table.sv
verilog/run_sequencer.sv
verilog/tap_address_gen.sv
verilog/sample_ring_buffer.sv
verilog/object_combiner.sv
verilog/drbe_local_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_drbe_local_ctrl.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic CLK
);

	// free running, starts low
	initial begin
		CLK = 1'b0;
		forever begin
			#(PERIOD / 2);
			CLK = ~CLK;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_drbe_local_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module tb_drbe_local_ctrl;

	// run budget in clock cycles with settle time per test
	localparam int RUN_CYCLES  = 2 * (12 + 1200 + 16 + 20 + 30 + 30);
	localparam int TEST_CYCLES = 16 + `DRBE_DEPTH + 2 + RUN_CYCLES + 6 * 40;

	logic                        CLK;
	logic                        reset;
	logic                        init_sram;
	logic                        cfg_valid;
	drbe_pkg::cfg_word_u         cfg_word;
	logic                        table_commit;
	logic [`DRBE_SCEN_LEN_W-1:0] scenario_len;
	logic                        start;
	logic                        sample_valid;
	drbe_pkg::sample_s           sample_in;
	logic                        mem_ready;
	logic                        run_active;
	logic                        out_valid;
	drbe_pkg::out_beat_s         out_beat;

	// accepted samples since the last clear by sample number
	drbe_pkg::sample_s   hist [$];
	// expected beats and their accepting cycle
	drbe_pkg::out_beat_s exp_q [$];
	int                  exp_cyc [$];
	drbe_pkg::out_beat_s e_beat;
	int                  e_cyc;
	// staging and active table models
	int s_delay [`DRBE_N_OBJ];
	int s_gain  [`DRBE_N_OBJ];
	int m_delay [`DRBE_N_OBJ];
	int m_gain  [`DRBE_N_OBJ];
	int cyc;
	int cur_len;
	int acc_in_run;
	int errors;
	int checks;
	int tests;
	int beats;
	int lasts;
	int sat_hits;

	tb_clock_gen #(.PERIOD(100)) clk_i (.CLK(CLK));

	drbe_local_ctrl_top dut_i (
		.CLK(CLK), .reset(reset), .init_sram(init_sram),
		.cfg_valid(cfg_valid), .cfg_word(cfg_word), .table_commit(table_commit),
		.scenario_len(scenario_len), .start(start),
		.sample_valid(sample_valid), .sample_in(sample_in),
		.mem_ready(mem_ready), .run_active(run_active),
		.out_valid(out_valid), .out_beat(out_beat)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic signed [`DRBE_DW-1:0] clamp16(input int v);
		if (v > 32767)
			return 16'sh7fff;
		if (v < -32768)
			return 16'sh8000;
		return 16'(v);
	endfunction

	// sum over objects of gain times x[n - delay]
	// x before index 0 reads as zero
	function automatic drbe_pkg::out_beat_s expected_beat(input int n, input logic last);
		drbe_pkg::out_beat_s b;
		drbe_pkg::sample_s   x;
		int                  acc_re;
		int                  acc_im;
		int                  idx;
		acc_re = 0;
		acc_im = 0;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			idx = n - m_delay[k];
			x = (idx >= 0) ? hist[idx] : '0;
			// each product shifted on its own
			acc_re += (int'(x.re) * m_gain[k]) >>> `DRBE_GAIN_FRAC;
			acc_im += (int'(x.im) * m_gain[k]) >>> `DRBE_GAIN_FRAC;
		end
		b.data.re = clamp16(acc_re);
		b.data.im = clamp16(acc_im);
		b.last    = last;
		return b;
	endfunction

	task automatic note_mismatch(input string name, input int got, input int exp);
		errors++;
		$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
	endtask

	task automatic note_error(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	////////////////////////////////////////
	// monitor and compare
	////////////////////////////////////////
	always @(posedge CLK) begin
		cyc <= cyc + 1;
	end

	// inputs are stable at the falling edge
	always @(negedge CLK) begin
		if (!reset) begin
			if (run_active && sample_valid) begin
				hist.push_back(sample_in);
				acc_in_run++;
				exp_q.push_back(expected_beat(hist.size() - 1, acc_in_run == cur_len));
				exp_cyc.push_back(cyc);
			end
			// new table from the next accepted sample on
			if (table_commit) begin
				m_delay = s_delay;
				m_gain  = s_gain;
			end
		end
	end

	always @(negedge CLK) begin
		if (!reset && out_valid) begin
			beats++;
			if (out_beat.last)
				lasts++;
			if (exp_q.size() == 0) begin
				note_error("output beat with no accepted sample behind it");
			end else begin
				e_beat = exp_q.pop_front();
				e_cyc  = exp_cyc.pop_front();
				checks++;
				if (out_beat.data.re !== e_beat.data.re)
					note_mismatch("out_beat.data.re", out_beat.data.re, e_beat.data.re);
				if (out_beat.data.im !== e_beat.data.im)
					note_mismatch("out_beat.data.im", out_beat.data.im, e_beat.data.im);
				if (out_beat.last !== e_beat.last)
					note_mismatch("out_beat.last", out_beat.last, e_beat.last);
				if (cyc - e_cyc != `DRBE_PIPE_LAT)
					note_mismatch("out_valid latency", cyc - e_cyc, `DRBE_PIPE_LAT);
				// DUT beat sitting on both clamp values
				if (int'(out_beat.data.re) == 32767 && int'(out_beat.data.im) == -32768)
					sat_hits++;
			end
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////
	task automatic step();
		@(posedge CLK);
		#10;
	endtask

	task automatic write_cfg(input logic kind, input int obj, input int val);
		if (kind == `DRBE_KIND_GAIN) begin
			cfg_word = drbe_pkg::cfg_word_u'({1'b1, 2'(obj), 13'b0, 16'(val)});
			s_gain[obj] = val;
		end else begin
			cfg_word = drbe_pkg::cfg_word_u'({1'b0, 2'(obj), 19'b0, 10'(val)});
			s_delay[obj] = val;
		end
		cfg_valid = 1'b1;
		step();
		cfg_valid = 1'b0;
	endtask

	task automatic commit_table();
		table_commit = 1'b1;
		step();
		table_commit = 1'b0;
	endtask

	// offers samples until the run has taken len of them
	task automatic run_scene(input int len, input int busy, input bit full_scale);
		cur_len      = len;
		acc_in_run   = 0;
		scenario_len = `DRBE_SCEN_LEN_W'(len);
		start        = 1'b1;
		step();
		start = 1'b0;
		while (acc_in_run < len) begin
			sample_valid = ($urandom % 100) < busy;
			sample_in    = $urandom;
			if (full_scale) begin
				sample_in.re = 16'(30000 + $urandom % 2000);
				sample_in.im = -sample_in.re;
			end
			step();
		end
		sample_valid = 1'b0;
	endtask

	task automatic drain_outputs();
		for (int i = 0; i < 20 && exp_q.size() != 0; i++)
			step();
		if (exp_q.size() != 0) begin
			note_error("expected output beats never arrived");
			exp_q.delete();
			exp_cyc.delete();
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "failed");
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		int n;
		int err0;
		int b0;
		int l0;
		int s0;
		void'($urandom(32'h40b5));
		reset        = 1'b1;
		init_sram    = 1'b0;
		cfg_valid    = 1'b0;
		cfg_word     = '0;
		table_commit = 1'b0;
		scenario_len = '0;
		start        = 1'b0;
		sample_valid = 1'b0;
		sample_in    = '0;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			s_delay[k] = 1;
			s_gain[k]  = 0;
		end
		m_delay = s_delay;
		m_gain  = s_gain;
		repeat (16) step();
		reset = 1'b0;

		// start is ignored until the clear is done
		err0 = errors;
		repeat (8) step();
		if (mem_ready || run_active || out_valid)
			note_error("mem_ready, run_active or out_valid not low after reset");
		scenario_len = `DRBE_SCEN_LEN_W'(5);
		start = 1'b1;
		step();
		start = 1'b0;
		repeat (2) step();
		if (run_active)
			note_error("start opened a run before the memory was cleared");
		init_sram = 1'b1;
		step();
		init_sram = 1'b0;
		hist.delete();
		n = 0;
		while (!mem_ready && n < `DRBE_DEPTH + 2) begin
			step();
			n++;
		end
		if (!mem_ready)
			note_error("mem_ready did not rise after the clear");
		report_test("clear", err0);

		// one object with unity gain and delay 5 back to back
		err0 = errors;
		write_cfg(`DRBE_KIND_DELAY, 0, 5);
		write_cfg(`DRBE_KIND_GAIN, 0, 16384);
		commit_table();
		run_scene(12, 100, 0);
		drain_outputs();
		report_test("single_object", err0);

		// four objects with a random table and gaps in the input
		err0 = errors;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			write_cfg(`DRBE_KIND_DELAY, k, 1 + $urandom % 1023);
			write_cfg(`DRBE_KIND_GAIN, k, int'($signed(16'($urandom))));
		end
		commit_table();
		run_scene(1200, 80, 0);
		drain_outputs();
		report_test("four_objects", err0);

		// total gain of four drives the sum past full scale
		err0 = errors;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			write_cfg(`DRBE_KIND_DELAY, k, k + 1);
			write_cfg(`DRBE_KIND_GAIN, k, 16384);
		end
		commit_table();
		s0 = sat_hits;
		run_scene(16, 100, 1);
		drain_outputs();
		if (sat_hits == s0)
			note_error("no output reached the clamp values");
		report_test("saturation", err0);

		// run length and samples outside a run
		err0 = errors;
		b0 = beats;
		l0 = lasts;
		run_scene(20, 70, 0);
		drain_outputs();
		if (beats - b0 != 20)
			note_mismatch("output beat count", beats - b0, 20);
		if (lasts - l0 != 1)
			note_mismatch("out_beat.last count", lasts - l0, 1);
		if (run_active)
			note_error("run_active still high after the run");
		sample_valid = 1'b1;
		repeat (10) begin
			sample_in = $urandom;
			step();
		end
		sample_valid = 1'b0;
		repeat (6) step();
		report_test("run_length", err0);

		// staging alone changes nothing until the commit
		err0 = errors;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			write_cfg(`DRBE_KIND_DELAY, k, 2 * k + 3);
			write_cfg(`DRBE_KIND_GAIN, k, 8000 - 3000 * k);
		end
		run_scene(30, 90, 0);
		drain_outputs();
		commit_table();
		run_scene(30, 90, 0);
		drain_outputs();
		report_test("table_commit", err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog
	initial begin
		#((TEST_CYCLES + 2000) * 100);
		$display("error at %0t: watchdog expired before the tests finished", $time);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/drbe_consts.svh
`ifndef DRBE_CONSTS_SVH
`define DRBE_CONSTS_SVH

////////////////////////////////////////
// scene size
////////////////////////////////////////
`define DRBE_N_OBJ       4
`define DRBE_OBJ_ID_W    2

// one component of a complex sample
`define DRBE_DW          16
`define DRBE_CFG_W       32
// widened sum of four shifted products, re or im
`define DRBE_ACC_W       34

////////////////////////////////////////
// sample memory and run length
////////////////////////////////////////
`define DRBE_DEPTH_LOG2  10
`define DRBE_DEPTH       1024
`define DRBE_SCEN_LEN_W  14

// gains are signed Q2.14, 16384 is unity
`define DRBE_GAIN_FRAC   14
// accepting cycle to out_valid
`define DRBE_PIPE_LAT    3

// config word kind bit
`define DRBE_KIND_DELAY  1'b0
`define DRBE_KIND_GAIN   1'b1

// run sequencer states
`define DRBE_ST_IDLE     1'b0
`define DRBE_ST_RUN      1'b1

`endif

// File: verilog/drbe_local_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module drbe_local_ctrl_top (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        init_sram,
	input  logic                        cfg_valid,
	input  drbe_pkg::cfg_word_u         cfg_word,
	input  logic                        table_commit,
	input  logic [`DRBE_SCEN_LEN_W-1:0] scenario_len,
	input  logic                        start,
	input  logic                        sample_valid,
	input  drbe_pkg::sample_s           sample_in,
	output logic                        mem_ready,
	output logic                        run_active,
	output logic                        out_valid,
	output drbe_pkg::out_beat_s         out_beat
);

	// active table
	drbe_pkg::tap_addr_t        act_delay [`DRBE_N_OBJ];
	logic signed [`DRBE_DW-1:0] act_gain  [`DRBE_N_OBJ];
	// accepted sample strobes
	logic                       accept;
	logic                       accept_last;
	// write port and read addresses
	logic                       wr_en;
	drbe_pkg::tap_addr_t        wr_addr;
	drbe_pkg::sample_s          wr_data;
	drbe_pkg::tap_addr_t        rd_addr [`DRBE_N_OBJ];
	logic                       rd_stage_valid;
	logic                       rd_stage_last;
	// memory read results
	drbe_pkg::sample_s          tap_sample [`DRBE_N_OBJ];
	logic                       tap_valid;
	logic                       tap_last;

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	scenario_table table_i (
		.CLK(CLK), .reset(reset),
		.cfg_valid(cfg_valid), .cfg_word(cfg_word), .table_commit(table_commit),
		.act_delay(act_delay), .act_gain(act_gain)
	);

	run_sequencer seq_i (
		.CLK(CLK), .reset(reset),
		.start(start), .mem_ready(mem_ready), .scenario_len(scenario_len),
		.sample_valid(sample_valid), .run_active(run_active),
		.accept(accept), .accept_last(accept_last)
	);

	////////////////////////////////////////
	// datapath, accept to out_valid is 3
	////////////////////////////////////////
	tap_address_gen addr_i (
		.CLK(CLK), .reset(reset),
		.accept(accept), .accept_last(accept_last), .sample_in(sample_in),
		.act_delay(act_delay),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_stage_valid(rd_stage_valid), .rd_stage_last(rd_stage_last)
	);

	sample_ring_buffer ring_i (
		.CLK(CLK), .reset(reset),
		.init_sram(init_sram), .run_active(run_active),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_stage_valid(rd_stage_valid), .rd_stage_last(rd_stage_last),
		.mem_ready(mem_ready),
		.tap_sample(tap_sample), .tap_valid(tap_valid), .tap_last(tap_last)
	);

	object_combiner comb_i (
		.CLK(CLK), .reset(reset),
		.tap_sample(tap_sample), .tap_valid(tap_valid), .tap_last(tap_last),
		.act_gain(act_gain),
		.out_valid(out_valid), .out_beat(out_beat)
	);

endmodule

`default_nettype wire

// File: verilog/drbe_pkg.sv
`default_nettype none
`include "drbe_consts.svh"

package drbe_pkg;

	////////////////////////////////////////
	// datapath types
	////////////////////////////////////////

	// one word of the sample memory
	typedef logic [`DRBE_DEPTH_LOG2-1:0] tap_addr_t;

	// complex sample, re in the upper half
	typedef struct packed {
		logic signed [`DRBE_DW-1:0] re;
		logic signed [`DRBE_DW-1:0] im;
	} sample_s;

	// output stream beat
	typedef struct packed {
		sample_s data;
		logic    last;
	} out_beat_s;

	////////////////////////////////////////
	// configuration word views
	////////////////////////////////////////

	// kind 0, sets one object's delay
	typedef struct packed {
		logic                                                kind;
		logic [`DRBE_OBJ_ID_W-1:0]                           obj_id;
		logic [`DRBE_CFG_W-`DRBE_OBJ_ID_W-`DRBE_DEPTH_LOG2-2:0] unused;
		tap_addr_t                                           delay;
	} cfg_delay_s;

	// kind 1, sets one object's gain
	typedef struct packed {
		logic                                         kind;
		logic [`DRBE_OBJ_ID_W-1:0]                    obj_id;
		logic [`DRBE_CFG_W-`DRBE_OBJ_ID_W-`DRBE_DW-2:0] unused;
		logic signed [`DRBE_DW-1:0]                   gain;
	} cfg_gain_s;

	// kind and obj_id sit at the same place in both views
	typedef union packed {
		cfg_delay_s delay_v;
		cfg_gain_s  gain_v;
	} cfg_word_u;

endpackage

`default_nettype wire

// File: verilog/object_combiner.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module object_combiner (
	input  logic                       CLK,
	input  logic                       reset,
	input  drbe_pkg::sample_s          tap_sample [`DRBE_N_OBJ],
	input  logic                       tap_valid,
	input  logic                       tap_last,
	input  logic signed [`DRBE_DW-1:0] act_gain   [`DRBE_N_OBJ],
	output logic                       out_valid,
	output drbe_pkg::out_beat_s        out_beat
);

	// full Q2.14 products
	logic signed [2*`DRBE_DW-1:0] prod_re [`DRBE_N_OBJ];
	logic signed [2*`DRBE_DW-1:0] prod_im [`DRBE_N_OBJ];
	// widened sums, no overflow for four taps
	logic signed [`DRBE_ACC_W-1:0] sum_re;
	logic signed [`DRBE_ACC_W-1:0] sum_im;

	// clamp to the signed sample range
	function automatic logic signed [`DRBE_DW-1:0] sat(input logic signed [`DRBE_ACC_W-1:0] v);
		logic signed [`DRBE_ACC_W-1:0] max_v;
		logic signed [`DRBE_ACC_W-1:0] min_v;
		max_v = {{(`DRBE_ACC_W-`DRBE_DW+1){1'b0}}, {(`DRBE_DW-1){1'b1}}};
		min_v = ~max_v;
		if (v > max_v) begin
			sat = {1'b0, {(`DRBE_DW-1){1'b1}}};
		end else if (v < min_v) begin
			sat = {1'b1, {(`DRBE_DW-1){1'b0}}};
		end else begin
			sat = v[`DRBE_DW-1:0];
		end
	endfunction

	////////////////////////////////////////
	// multiply, shift, sum
	////////////////////////////////////////
	always_comb begin
		sum_re = '0;
		sum_im = '0;
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			prod_re[k] = tap_sample[k].re * act_gain[k];
			prod_im[k] = tap_sample[k].im * act_gain[k];
			// arithmetic shift per product, before the sum
			sum_re = sum_re + `DRBE_ACC_W'(prod_re[k] >>> `DRBE_GAIN_FRAC);
			sum_im = sum_im + `DRBE_ACC_W'(prod_im[k] >>> `DRBE_GAIN_FRAC);
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= tap_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (tap_valid) begin
			out_beat.data.re <= sat(sum_re);
			out_beat.data.im <= sat(sum_im);
			out_beat.last    <= tap_last;
		end
	end

endmodule

`default_nettype wire

// File: verilog/run_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module run_sequencer (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        start,
	input  logic                        mem_ready,
	input  logic [`DRBE_SCEN_LEN_W-1:0] scenario_len,
	input  logic                        sample_valid,
	output logic                        run_active,
	output logic                        accept,
	output logic                        accept_last
);

	logic                        state;
	// samples still to take in this run
	logic [`DRBE_SCEN_LEN_W-1:0] remaining;

	////////////////////////////////////////
	// strobe qualification
	////////////////////////////////////////
	assign run_active  = (state == `DRBE_ST_RUN);
	// strobes outside a run are dropped here
	assign accept      = run_active & sample_valid;
	assign accept_last = accept & (remaining == `DRBE_SCEN_LEN_W'(1));

	////////////////////////////////////////
	// idle / run FSM
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			state     <= `DRBE_ST_IDLE;
			remaining <= '0;
		end else begin
			case (state)
				`DRBE_ST_IDLE: begin
					// only with a cleared memory
					// zero length run is not opened
					if (start && mem_ready && (scenario_len != '0)) begin
						state     <= `DRBE_ST_RUN;
						remaining <= scenario_len;
					end
				end
				`DRBE_ST_RUN: begin
					if (accept) begin
						remaining <= remaining - 1'b1;
						// run_active drops the cycle after
						if (accept_last) begin
							state <= `DRBE_ST_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/sample_ring_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module sample_ring_buffer (
	input  logic                CLK,
	input  logic                reset,
	input  logic                init_sram,
	input  logic                run_active,
	input  logic                wr_en,
	input  drbe_pkg::tap_addr_t wr_addr,
	input  drbe_pkg::sample_s   wr_data,
	input  drbe_pkg::tap_addr_t rd_addr [`DRBE_N_OBJ],
	input  logic                rd_stage_valid,
	input  logic                rd_stage_last,
	output logic                mem_ready,
	output drbe_pkg::sample_s   tap_sample [`DRBE_N_OBJ],
	output logic                tap_valid,
	output logic                tap_last
);

	drbe_pkg::sample_s   mem [`DRBE_DEPTH];

	// clear sequence
	logic                clearing;
	drbe_pkg::tap_addr_t clr_addr;

	////////////////////////////////////////
	// clear control
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			clearing  <= 1'b0;
			clr_addr  <= '0;
			mem_ready <= 1'b0;
			tap_valid <= 1'b0;
			tap_last  <= 1'b0;
		end else begin
			// valid and last ride with the read
			tap_valid <= rd_stage_valid;
			tap_last  <= rd_stage_last;
			if (clearing) begin
				clr_addr <= clr_addr + 1'b1;
				// last word zeroed this cycle
				if (clr_addr == drbe_pkg::tap_addr_t'(`DRBE_DEPTH - 1)) begin
					clearing  <= 1'b0;
					mem_ready <= 1'b1;
				end
			end else if (init_sram && !run_active) begin
				// ignored while a run is open
				clearing  <= 1'b1;
				clr_addr  <= '0;
				mem_ready <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// memory, one write and four reads
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (clearing) begin
			mem[clr_addr] <= '0;
		end else if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// read first, delay 1023 hits the slot written this edge
		for (int k = 0; k < `DRBE_N_OBJ; k++) begin
			tap_sample[k] <= mem[rd_addr[k]];
		end
	end

endmodule

`default_nettype wire

// File: verilog/scenario_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module scenario_table (
	input  logic                       CLK,
	input  logic                       reset,
	input  logic                       cfg_valid,
	input  drbe_pkg::cfg_word_u        cfg_word,
	input  logic                       table_commit,
	output drbe_pkg::tap_addr_t        act_delay [`DRBE_N_OBJ],
	output logic signed [`DRBE_DW-1:0] act_gain  [`DRBE_N_OBJ]
);

	// staging copy, loaded word by word
	drbe_pkg::tap_addr_t        stg_delay [`DRBE_N_OBJ];
	logic signed [`DRBE_DW-1:0] stg_gain  [`DRBE_N_OBJ];

	// committed gains travel down alongside the samples
	// so a sample never mixes old delays with new gains
	logic signed [`DRBE_DW-1:0] gain_pipe [`DRBE_PIPE_LAT][`DRBE_N_OBJ];

	////////////////////////////////////////
	// staging writes
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int k = 0; k < `DRBE_N_OBJ; k++) begin
				stg_delay[k] <= drbe_pkg::tap_addr_t'(1);
				stg_gain[k]  <= '0;
			end
		end else if (cfg_valid) begin
			// kind bit picks the view
			case (cfg_word.delay_v.kind)
				`DRBE_KIND_DELAY: begin
					stg_delay[cfg_word.delay_v.obj_id] <= cfg_word.delay_v.delay;
				end
				`DRBE_KIND_GAIN: begin
					stg_gain[cfg_word.gain_v.obj_id] <= cfg_word.gain_v.gain;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// commit, whole table at once
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int k = 0; k < `DRBE_N_OBJ; k++) begin
				act_delay[k] <= drbe_pkg::tap_addr_t'(1);
			end
		end else if (table_commit) begin
			// addresses of the next accepted sample use this
			act_delay <= stg_delay;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `DRBE_PIPE_LAT; i++) begin
				for (int k = 0; k < `DRBE_N_OBJ; k++) begin
					gain_pipe[i][k] <= '0;
				end
			end
		end else begin
			if (table_commit) begin
				gain_pipe[0] <= stg_gain;
			end
			// two more stages, address reg and memory read
			for (int i = 1; i < `DRBE_PIPE_LAT; i++) begin
				gain_pipe[i] <= gain_pipe[i-1];
			end
		end
	end

	// reaches the multiplier with the first new sample
	assign act_gain = gain_pipe[`DRBE_PIPE_LAT-1];

endmodule

`default_nettype wire

// File: verilog/tap_address_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "drbe_consts.svh"

module tap_address_gen (
	input  logic                CLK,
	input  logic                reset,
	input  logic                accept,
	input  logic                accept_last,
	input  drbe_pkg::sample_s   sample_in,
	input  drbe_pkg::tap_addr_t act_delay [`DRBE_N_OBJ],
	output logic                wr_en,
	output drbe_pkg::tap_addr_t wr_addr,
	output drbe_pkg::sample_s   wr_data,
	output drbe_pkg::tap_addr_t rd_addr [`DRBE_N_OBJ],
	output logic                rd_stage_valid,
	output logic                rd_stage_last
);

	// next free slot, wraps with the depth
	drbe_pkg::tap_addr_t wr_ptr;

	// write lands at the end of the accepting cycle
	assign wr_en   = accept;
	assign wr_addr = wr_ptr;
	assign wr_data = sample_in;

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr         <= '0;
			rd_stage_valid <= 1'b0;
			rd_stage_last  <= 1'b0;
		end else begin
			rd_stage_valid <= accept;
			rd_stage_last  <= accept & accept_last;
			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// tap k sits delay_k slots behind the sample just written
	// modulo depth by the address width
	always_ff @(posedge CLK) begin
		if (accept) begin
			for (int k = 0; k < `DRBE_N_OBJ; k++) begin
				rd_addr[k] <= wr_ptr - act_delay[k];
			end
		end
	end

endmodule

`default_nettype wire
